/* paint_pkg.sv */
// Shared types and constants of the paint engine, imported by every RTL file
`default_nettype none

package paint_pkg;

    // Screen coordinates on a 640 x 480 raster
    typedef logic [9:0] x_coord_t;
    typedef logic [8:0] y_coord_t;

    // RGB 3:3:3
    typedef logic [8:0] color_t;

    // Brush size in odd steps
    typedef logic [4:0] size_t;

    // Tool code as it leaves on the tool port
    typedef enum logic [1:0] {
        BOX   = 2'd0,
        PEN   = 2'd1,
        ERASE = 2'd2,
        FILL  = 2'd3
    } tool_t;

    // Toolbar strip at the top of the screen
    localparam y_coord_t TOOLBAR_BOTTOM = 9'd50;
    localparam int NUM_REGIONS = 15;

    // Exclusive right edge of each region from left to right
    localparam x_coord_t [0:NUM_REGIONS-1] TOOLBAR_EDGES = '{
        10'd66,  10'd108, 10'd150, 10'd192, 10'd234,
        10'd276, 10'd318, 10'd360, 10'd402, 10'd444,
        10'd486, 10'd538, 10'd572, 10'd606, 10'd640
    };

    // Region indices with the nine colours at 1..9
    localparam logic [3:0] REGION_BOX   = 4'd0;
    localparam logic [3:0] REGION_PEN   = 4'd10;
    localparam logic [3:0] REGION_ERASE = 4'd11;
    localparam logic [3:0] REGION_FILL  = 4'd12;
    localparam logic [3:0] REGION_INC   = 4'd13;
    localparam logic [3:0] REGION_DEC   = 4'd14;
    localparam logic [3:0] REGION_NONE  = 4'd15;

    // Preset palette
    localparam color_t RED    = 9'b111_000_000;
    localparam color_t ORANGE = 9'b111_011_000;
    localparam color_t YELLOW = 9'b111_111_000;
    localparam color_t GREEN  = 9'b000_111_000;
    localparam color_t BLUE   = 9'b000_000_111;
    localparam color_t PURPLE = 9'b111_000_111;
    localparam color_t BLACK  = 9'b000_000_000;
    localparam color_t WHITE  = 9'b111_111_111;
    localparam color_t GRAY   = 9'b100_100_100;

    // Paintable area with inclusive limits
    localparam x_coord_t CANVAS_X_MIN = 10'd10;
    localparam x_coord_t CANVAS_X_MAX = 10'd630;
    localparam y_coord_t CANVAS_Y_MIN = 9'd51;
    localparam y_coord_t CANVAS_Y_MAX = 9'd470;

    // Brush size range
    localparam size_t MIN_SIZE  = 5'd1;
    localparam size_t MAX_SIZE  = 5'd31;
    localparam size_t SIZE_STEP = 5'd2;

endpackage

`default_nettype wire

/* paint_job_if.sv */
// Carries one rectangle job from the toolbar decoder to the raster walker
`timescale 1ns/1ps
`default_nettype none

interface paint_job_if;
    import paint_pkg::*;

    // One-cycle request, no handshake back
    logic     start;
    // Top left corner of the rectangle
    x_coord_t origin_x;
    y_coord_t origin_y;
    // Pixel counts minus one
    x_coord_t width;
    y_coord_t height;
    // Outline thickness, zero for a solid rectangle
    size_t    thickness;
    color_t   color;

    modport source (
        output start, origin_x, origin_y, width, height, thickness, color
    );

    modport sink (
        input start, origin_x, origin_y, width, height, thickness, color
    );

endinterface

`default_nettype wire

/* pixel_if.sv */
// Carries raster offsets, job origin and colour from the walker to the clipper
`timescale 1ns/1ps
`default_nettype none

interface pixel_if;
    import paint_pkg::*;

    // High for each painted scan position
    logic     write;
    // Offset inside the job rectangle
    x_coord_t off_x;
    y_coord_t off_y;
    // Job origin, constant over a job
    x_coord_t origin_x;
    y_coord_t origin_y;
    color_t   color;

    modport source (output write, off_x, off_y, origin_x, origin_y, color);
    modport sink   (input  write, off_x, off_y, origin_x, origin_y, color);

endinterface

`default_nettype wire

/* toolbar_decode.sv */
// Turns clicks into tool, colour and size updates or rectangle jobs for the raster walker
`timescale 1ns/1ps
`default_nettype none

module toolbar_decode (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                click,
    input  logic                color_load,
    input  paint_pkg::color_t   sw_color,
    input  paint_pkg::x_coord_t cursor_x,
    input  paint_pkg::y_coord_t cursor_y,
    paint_job_if.source         job,
    output paint_pkg::tool_t    tool,
    output paint_pkg::size_t    size
);
    import paint_pkg::*;

    // Sampled click and cursor
    logic       click_q;
    logic       click_prev;
    x_coord_t   cur_x;
    y_coord_t   cur_y;

    logic       press;
    logic       release_edge;
    logic       on_bar;
    logic [3:0] region;
    logic       is_preset;

    color_t     color_q;

    // Pen and eraser square corner
    size_t      half;
    x_coord_t   stamp_x;
    y_coord_t   stamp_y;

    // Box drag state
    logic       box_armed;
    x_coord_t   anchor_x;
    y_coord_t   anchor_y;
    x_coord_t   box_x0;
    x_coord_t   box_x1;
    y_coord_t   box_y0;
    y_coord_t   box_y1;

    // Next job
    logic       job_go;
    x_coord_t   nxt_x;
    y_coord_t   nxt_y;
    x_coord_t   nxt_w;
    y_coord_t   nxt_h;
    size_t      nxt_th;
    color_t     nxt_col;

    // First region whose right edge lies beyond x
    function automatic logic [3:0] region_of(x_coord_t x);
        logic [3:0] idx;
        idx = REGION_NONE;
        for (int i = NUM_REGIONS - 1; i >= 0; i--) begin
            if (x < TOOLBAR_EDGES[i])
                idx = 4'(i);
        end
        return idx;
    endfunction

    function automatic color_t preset_color(logic [3:0] idx);
        case (idx)
            4'd1:    return RED;
            4'd2:    return ORANGE;
            4'd3:    return YELLOW;
            4'd4:    return GREEN;
            4'd5:    return BLUE;
            4'd6:    return PURPLE;
            4'd7:    return BLACK;
            4'd8:    return WHITE;
            default: return GRAY;
        endcase
    endfunction

    // Click register plus one more stage for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            click_q    <= 1'b0;
            click_prev <= 1'b0;
        end else begin
            click_q    <= click;
            click_prev <= click_q;
        end
    end

    // Cursor sampled alongside the click
    always_ff @(posedge clk) begin
        cur_x <= cursor_x;
        cur_y <= cursor_y;
    end

    assign press        = click_q & ~click_prev;
    assign release_edge = ~click_q & click_prev;
    assign on_bar       = (cur_y <= TOOLBAR_BOTTOM);
    assign region       = region_of(cur_x);
    assign is_preset    = (region >= 4'd1) && (region <= 4'd9);

    // Tool select
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tool <= PEN;
        end else if (press && on_bar) begin
            case (region)
                REGION_BOX:   tool <= BOX;
                REGION_PEN:   tool <= PEN;
                REGION_ERASE: tool <= ERASE;
                REGION_FILL:  tool <= FILL;
                default:      tool <= tool;
            endcase
        end
    end

    // Size steps by two and saturates at both ends
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size <= MIN_SIZE;
        end else if (press && on_bar) begin
            if (region == REGION_INC && size < MAX_SIZE)
                size <= size + SIZE_STEP;
            else if (region == REGION_DEC && size > MIN_SIZE)
                size <= size - SIZE_STEP;
        end
    end

    // Switch load wins over a palette click
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            color_q <= BLACK;
        else if (color_load)
            color_q <= sw_color;
        else if (press && on_bar && is_preset)
            color_q <= preset_color(region);
    end

    // Box press only arms, release fires the job
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            box_armed <= 1'b0;
        else if (press && !on_bar && tool == BOX)
            box_armed <= 1'b1;
        else if (release_edge)
            box_armed <= 1'b0;
    end

    always_ff @(posedge clk) begin
        if (press && !on_bar) begin
            anchor_x <= cur_x;
            anchor_y <= cur_y;
        end
    end

    // Square centred on the cursor, kept off negative coordinates
    assign half    = size >> 1;
    assign stamp_x = (cur_x < x_coord_t'(half)) ? '0 : cur_x - x_coord_t'(half);
    assign stamp_y = (cur_y < y_coord_t'(half)) ? '0 : cur_y - y_coord_t'(half);

    // Drag corners in either direction
    assign box_x0 = (cur_x < anchor_x) ? cur_x : anchor_x;
    assign box_x1 = (cur_x < anchor_x) ? anchor_x : cur_x;
    assign box_y0 = (cur_y < anchor_y) ? cur_y : anchor_y;
    assign box_y1 = (cur_y < anchor_y) ? anchor_y : cur_y;

    always_comb begin
        job_go  = 1'b0;
        nxt_x   = stamp_x;
        nxt_y   = stamp_y;
        nxt_w   = x_coord_t'(size) - 10'd1;
        nxt_h   = y_coord_t'(size) - 9'd1;
        nxt_th  = '0;
        nxt_col = (tool == ERASE) ? WHITE : color_q;
        if (release_edge && box_armed) begin
            job_go = 1'b1;
            nxt_x  = box_x0;
            nxt_y  = box_y0;
            nxt_w  = box_x1 - box_x0;
            nxt_h  = box_y1 - box_y0;
            nxt_th = size;
        end else if (press && !on_bar) begin
            case (tool)
                PEN, ERASE: job_go = 1'b1;
                FILL: begin
                    job_go = 1'b1;
                    nxt_x  = CANVAS_X_MIN;
                    nxt_y  = CANVAS_Y_MIN;
                    nxt_w  = CANVAS_X_MAX - CANVAS_X_MIN;
                    nxt_h  = CANVAS_Y_MAX - CANVAS_Y_MIN;
                end
                default: job_go = 1'b0;
            endcase
        end
    end

    // Job strobe one cycle after the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            job.start <= 1'b0;
        else
            job.start <= job_go;
    end

    always_ff @(posedge clk) begin
        if (job_go) begin
            job.origin_x  <= nxt_x;
            job.origin_y  <= nxt_y;
            job.width     <= nxt_w;
            job.height    <= nxt_h;
            job.thickness <= nxt_th;
            job.color     <= nxt_col;
        end
    end

endmodule

`default_nettype wire

/* stroke_raster.sv */
// Walks a job rectangle row by row and flags the solid or outline pixels
`timescale 1ns/1ps
`default_nettype none

module stroke_raster (
    input  logic        clk,
    input  logic        rst_n,
    paint_job_if.sink   job,
    pixel_if.source     pix,
    output logic        busy
);
    import paint_pkg::*;

    // Latched job
    x_coord_t org_x;
    y_coord_t org_y;
    x_coord_t width;
    y_coord_t height;
    size_t    thick;
    color_t   col;

    // Scan position
    x_coord_t cnt_x;
    y_coord_t cnt_y;

    logic     near_x;
    logic     near_y;
    logic     painted;

    // x fastest, busy drops after the last position
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            cnt_x <= '0;
            cnt_y <= '0;
        end else if (!busy) begin
            // A start while busy is simply lost
            if (job.start) begin
                busy  <= 1'b1;
                cnt_x <= '0;
                cnt_y <= '0;
            end
        end else if (cnt_x == width) begin
            cnt_x <= '0;
            if (cnt_y == height)
                busy <= 1'b0;
            else
                cnt_y <= cnt_y + 9'd1;
        end else begin
            cnt_x <= cnt_x + 10'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && job.start) begin
            org_x  <= job.origin_x;
            org_y  <= job.origin_y;
            width  <= job.width;
            height <= job.height;
            thick  <= job.thickness;
            col    <= job.color;
        end
    end

    // Distance to the nearer edge under the thickness
    assign near_x = (cnt_x < x_coord_t'(thick)) ||
                    ((width - cnt_x) < x_coord_t'(thick));
    assign near_y = (cnt_y < y_coord_t'(thick)) ||
                    ((height - cnt_y) < y_coord_t'(thick));

    // Zero thickness paints everything
    assign painted = (thick == '0) || near_x || near_y;

    assign pix.write    = busy && painted;
    assign pix.off_x    = cnt_x;
    assign pix.off_y    = cnt_y;
    assign pix.origin_x = org_x;
    assign pix.origin_y = org_y;
    assign pix.color    = col;

endmodule

`default_nettype wire

/* canvas_clip.sv */
// Forms absolute pixel positions, clamps them into the canvas and registers the write port
`timescale 1ns/1ps
`default_nettype none

module canvas_clip (
    input  logic                clk,
    input  logic                rst_n,
    pixel_if.sink               pix,
    output paint_pkg::x_coord_t pix_x,
    output paint_pkg::y_coord_t pix_y,
    output paint_pkg::color_t   pix_color,
    output logic                pix_write
);
    import paint_pkg::*;

    // One extra bit so a sum past the screen still clamps
    logic [10:0] sum_x;
    logic [9:0]  sum_y;
    x_coord_t    clip_x;
    y_coord_t    clip_y;

    assign sum_x = {1'b0, pix.origin_x} + {1'b0, pix.off_x};
    assign sum_y = {1'b0, pix.origin_y} + {1'b0, pix.off_y};

    always_comb begin
        if (sum_x < {1'b0, CANVAS_X_MIN})
            clip_x = CANVAS_X_MIN;
        else if (sum_x > {1'b0, CANVAS_X_MAX})
            clip_x = CANVAS_X_MAX;
        else
            clip_x = sum_x[9:0];
        // Keeps stamps out of the toolbar
        if (sum_y < {1'b0, CANVAS_Y_MIN})
            clip_y = CANVAS_Y_MIN;
        else if (sum_y > {1'b0, CANVAS_Y_MAX})
            clip_y = CANVAS_Y_MAX;
        else
            clip_y = sum_y[8:0];
    end

    // Strobe one cycle behind the walker
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            pix_write <= 1'b0;
        else
            pix_write <= pix.write;
    end

    always_ff @(posedge clk) begin
        pix_x     <= clip_x;
        pix_y     <= clip_y;
        pix_color <= pix.color;
    end

endmodule

`default_nettype wire

/* mini_paint.sv */
// Paint engine top level, board keys and cursor in, frame buffer pixel writes out
`timescale 1ns/1ps
`default_nettype none

module mini_paint (
    input  logic       CLOCK_50,
    input  logic [3:0] KEY,
    input  logic [8:0] SW,
    input  logic       left_button,
    input  logic [9:0] cursor_x,
    input  logic [8:0] cursor_y,
    output logic [9:0] pix_x,
    output logic [8:0] pix_y,
    output logic [8:0] pix_color,
    output logic       pix_write,
    output logic [1:0] tool,
    output logic [4:0] size,
    output logic       busy
);

    // Keys are active low
    logic rst_n;
    logic color_load;
    logic click;

    assign rst_n      = KEY[0];
    assign color_load = ~KEY[1];
    // Mouse button qualified by KEY[3]
    assign click      = left_button & ~KEY[3];

    paint_job_if job_bus ();
    pixel_if     pix_bus ();

    toolbar_decode u_decode (
        .clk        (CLOCK_50),
        .rst_n      (rst_n),
        .click      (click),
        .color_load (color_load),
        .sw_color   (SW),
        .cursor_x   (cursor_x),
        .cursor_y   (cursor_y),
        .job        (job_bus),
        .tool       (tool),
        .size       (size)
    );

    stroke_raster u_raster (
        .clk   (CLOCK_50),
        .rst_n (rst_n),
        .job   (job_bus),
        .pix   (pix_bus),
        .busy  (busy)
    );

    // Registered write port
    canvas_clip u_clip (
        .clk       (CLOCK_50),
        .rst_n     (rst_n),
        .pix       (pix_bus),
        .pix_x     (pix_x),
        .pix_y     (pix_y),
        .pix_color (pix_color),
        .pix_write (pix_write)
    );

endmodule

`default_nettype wire

/* tb_mini_paint.sv */
// Testbench for the paint engine, replays the golden records and checks every pixel write
`timescale 1ns/1ps
`default_nettype none

module tb_mini_paint;

    // Golden record layout, one record per file line
    localparam int REC_WORDS        = 14;
    localparam int MAX_RECORDS      = 32;
    localparam int RESET_CYCLES     = 16;
    localparam int BUSY_START_LIMIT = 20;
    // Full canvas fill is 260820 positions
    localparam int BUSY_END_LIMIT   = 300000;

    logic       CLOCK_50;
    logic [3:0] KEY;
    logic [8:0] SW;
    logic       left_button;
    logic [9:0] cursor_x;
    logic [8:0] cursor_y;
    logic [9:0] pix_x;
    logic [8:0] pix_y;
    logic [8:0] pix_color;
    logic       pix_write;
    logic [1:0] tool;
    logic [4:0] size;
    logic       busy;

    logic [31:0] golden [0:REC_WORDS*MAX_RECORDS-1];

    string       test_name;
    logic [15:0] lfsr_state;

    // Outputs sampled at the falling edge
    logic        busy_s;
    logic [1:0]  tool_s;
    logic [4:0]  size_s;

    // Per record pixel statistics and limits
    logic [31:0] pix_count;
    logic [9:0]  seen_x_min;
    logic [9:0]  seen_x_max;
    logic [8:0]  seen_y_min;
    logic [8:0]  seen_y_max;
    logic [9:0]  exp_x_min;
    logic [9:0]  exp_x_max;
    logic [8:0]  exp_y_min;
    logic [8:0]  exp_y_max;
    logic [8:0]  exp_color;

    mini_paint uut (
        .CLOCK_50    (CLOCK_50),
        .KEY         (KEY),
        .SW          (SW),
        .left_button (left_button),
        .cursor_x    (cursor_x),
        .cursor_y    (cursor_y),
        .pix_x       (pix_x),
        .pix_y       (pix_y),
        .pix_color   (pix_color),
        .pix_write   (pix_write),
        .tool        (tool),
        .size        (size),
        .busy        (busy)
    );

    // 20 ns period
    always #10 CLOCK_50 = ~CLOCK_50;

    task automatic fail_with(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act) else begin
            $display("MISMATCH %s %s expected 0x%0h actual 0x%0h", test_name, what, exp, act);
            $display("Simulation failed");
            $fatal(1, "run stopped");
        end
    endtask

    // Fibonacci LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // One LFSR step per bit
    task automatic draw_bits(input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val = (val << 1) | int'(lfsr_state[0]);
        end
    endtask

    function automatic string op_name(input logic [3:0] op);
        case (op)
            4'h0:    return "toolbar_click";
            4'h1:    return "canvas_click";
            4'h2:    return "box_drag";
            4'h3:    return "switch_load";
            4'h4:    return "idle";
            4'h5:    return "size_clicks";
            default: return "unknown";
        endcase
    endfunction

    // Sample at the falling edge, return at the next rising edge for driving
    task automatic tick();
        @(negedge CLOCK_50);
        busy_s = busy;
        tool_s = tool;
        size_s = size;
        if (pix_write) begin
            pix_count = pix_count + 32'd1;
            check_value("pixel colour", 32'(exp_color), 32'(pix_color));
            assert (pix_x >= exp_x_min && pix_x <= exp_x_max) else
                fail_with($sformatf("%s pixel x %0d lies outside %0d..%0d",
                                    test_name, pix_x, exp_x_min, exp_x_max));
            assert (pix_y >= exp_y_min && pix_y <= exp_y_max) else
                fail_with($sformatf("%s pixel y %0d lies outside %0d..%0d",
                                    test_name, pix_y, exp_y_min, exp_y_max));
            if (pix_x < seen_x_min)
                seen_x_min = pix_x;
            if (pix_x > seen_x_max)
                seen_x_max = pix_x;
            if (pix_y < seen_y_min)
                seen_y_min = pix_y;
            if (pix_y > seen_y_max)
                seen_y_max = pix_y;
        end
        @(posedge CLOCK_50);
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        tick();
        while (busy_s != level && n < limit) begin
            tick();
            n++;
        end
        assert (busy_s == level) else
            fail_with($sformatf("%s timed out waiting for busy to become %0d",
                                test_name, level));
    endtask

    task automatic bar_click(input logic [9:0] x, input logic [8:0] y);
        cursor_x    <= x;
        cursor_y    <= y;
        left_button <= 1'b1;
        repeat (3) tick();
        left_button <= 1'b0;
        repeat (3) tick();
    endtask

    // Stamp or fill, button held until the walker starts
    task automatic canvas_click(input logic [9:0] x, input logic [8:0] y);
        cursor_x    <= x;
        cursor_y    <= y;
        left_button <= 1'b1;
        wait_busy(1'b1, BUSY_START_LIMIT);
        left_button <= 1'b0;
        wait_busy(1'b0, BUSY_END_LIMIT);
        // Registered write port lags by one cycle
        repeat (2) tick();
    endtask

    task automatic box_drag(input logic [9:0] x0, input logic [8:0] y0,
                            input logic [9:0] x1, input logic [8:0] y1);
        cursor_x    <= x0;
        cursor_y    <= y0;
        left_button <= 1'b1;
        repeat (3) tick();
        // Drag to the far corner with the button still down
        cursor_x    <= x1;
        cursor_y    <= y1;
        repeat (3) tick();
        left_button <= 1'b0;
        wait_busy(1'b1, BUSY_START_LIMIT);
        wait_busy(1'b0, BUSY_END_LIMIT);
        repeat (2) tick();
    endtask

    task automatic load_switches(input logic [8:0] value);
        SW     <= value;
        KEY[1] <= 1'b0;
        repeat (2) tick();
        KEY[1] <= 1'b1;
        repeat (2) tick();
    endtask

    // Random x inside the region, 6 bits folded onto its width
    task automatic size_clicks(input logic [9:0] lo, input logic [9:0] width,
                               input logic [8:0] y, input logic [8:0] n);
        int offset;
        for (int i = 0; i < int'(n); i++) begin
            draw_bits(6, offset);
            offset = offset % int'(width);
            bar_click(lo + 10'(offset), y);
        end
    endtask

    task automatic run_record(input int rec, input int base);
        logic [3:0] op;
        logic [9:0] x0;
        logic [8:0] y0;
        logic [9:0] x1;
        logic [8:0] y1;
        op         = golden[base][3:0];
        x0         = golden[base+1][9:0];
        y0         = golden[base+2][8:0];
        x1         = golden[base+3][9:0];
        y1         = golden[base+4][8:0];
        exp_color  = golden[base+8][8:0];
        exp_x_min  = golden[base+10][9:0];
        exp_x_max  = golden[base+11][9:0];
        exp_y_min  = golden[base+12][8:0];
        exp_y_max  = golden[base+13][8:0];
        test_name  = $sformatf("rec%0d_%s", rec, op_name(op));
        pix_count  = '0;
        seen_x_min = '1;
        seen_x_max = '0;
        seen_y_min = '1;
        seen_y_max = '0;
        case (op)
            4'h0:    bar_click(x0, y0);
            4'h1:    canvas_click(x0, y0);
            4'h2:    box_drag(x0, y0, x1, y1);
            4'h3:    load_switches(golden[base+5][8:0]);
            4'h4:    repeat (50) tick();
            4'h5:    size_clicks(x0, x1, y0, y1);
            default: fail_with($sformatf("record %0d holds unknown operation %0h", rec, op));
        endcase
        check_value("tool", 32'(golden[base+6][1:0]), 32'(tool_s));
        check_value("size", 32'(golden[base+7][4:0]), 32'(size_s));
        check_value("pixel count", golden[base+9], pix_count);
        // Clamped bounding box only for jobs that paint
        if (golden[base+9] != 32'd0) begin
            check_value("x min", 32'(exp_x_min), 32'(seen_x_min));
            check_value("x max", 32'(exp_x_max), 32'(seen_x_max));
            check_value("y min", 32'(exp_y_min), 32'(seen_y_min));
            check_value("y max", 32'(exp_y_max), 32'(seen_y_max));
        end
    endtask

    initial begin
        int   rec;
        logic done;
        CLOCK_50    = 1'b0;
        // Reset held, no colour load, KEY[3] low enables the button
        KEY         = 4'b0110;
        SW          = '0;
        left_button = 1'b0;
        cursor_x    = '0;
        cursor_y    = '0;
        lfsr_state  = 16'd34441;
        test_name   = "reset";
        busy_s      = 1'b0;
        tool_s      = '0;
        size_s      = '0;
        pix_count   = '0;
        exp_x_min   = '0;
        exp_x_max   = '0;
        exp_y_min   = '0;
        exp_y_max   = '0;
        exp_color   = '0;
        $readmemh("paint_golden.txt", golden);
        repeat (RESET_CYCLES) @(posedge CLOCK_50);
        KEY[0] <= 1'b1;
        tick();
        rec  = 0;
        done = 1'b0;
        while (!done && rec < MAX_RECORDS) begin
            if (golden[rec*REC_WORDS][3:0] == 4'hF)
                done = 1'b1;
            else
                run_record(rec, rec * REC_WORDS);
            rec++;
        end
        if (done) begin
            $display("Simulation passed");
            $finish;
        end else begin
            fail_with("golden file ended without an end record");
        end
    end

endmodule

`default_nettype wire

/* paint_golden.txt */
// op x0 y0 x1 y1 sw tool size color count xmin xmax ymin ymax, all hex
// op 0 toolbar 1 canvas 2 drag 3 switch 4 idle 5 size (x0 edge, x1 width, y1 repeats) F end
4 0 0 0 0 0 1 1 0 0 0 0 0 0
1 64 64 0 0 0 1 1 0 1 64 64 64 64
5 23C 14 22 5 0 1 B 0 0 0 0 0 0
1 C8 C8 0 0 0 1 B 0 79 C3 CD C3 CD
0 50 14 0 0 0 1 B 0 0 0 0 0 0
1 12C 12C 0 0 0 1 B 1C0 79 127 131 127 131
3 0 0 0 0 A5 1 B 0 0 0 0 0 0
1 190 12C 0 0 0 1 B A5 79 18B 195 127 131
0 1F4 14 0 0 0 2 B 0 0 0 0 0 0
1 96 190 0 0 0 2 B 1FF 79 91 9B 18B 195
0 1CC 14 0 0 0 1 B 0 0 0 0 0 0
5 25E 14 22 2 0 1 7 0 0 0 0 0 0
1 14 34 0 0 0 1 7 A5 31 11 17 33 37
1 C 64 0 0 0 1 7 A5 31 A F 61 67
5 23C 14 22 14 0 1 1F 0 0 0 0 0 0
5 25E 14 22 14 0 1 1 0 0 0 0 0 0
0 1E 14 0 0 0 0 1 0 0 0 0 0 0
5 23C 14 22 2 0 0 5 0 0 0 0 0 0
2 64 64 9F 8B 0 0 5 A5 384 64 9F 64 8B
2 12C C8 FA B4 0 0 5 A5 26C FA 12C B4 C8
0 D2 14 0 0 0 0 5 0 0 0 0 0 0
0 226 14 0 0 0 3 5 0 0 0 0 0 0
1 140 F0 0 0 0 3 5 38 3FAD4 A 276 33 1D6
F 0 0 0 0 0 0 0 0 0 0 0 0 0

/* project.f */
paint_pkg.sv
paint_job_if.sv
pixel_if.sv
toolbar_decode.sv
stroke_raster.sv
canvas_clip.sv
mini_paint.sv
tb_mini_paint.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the paint engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f project.f \
    --top-module tb_mini_paint \
    -Mdir obj_dir

./obj_dir/Vtb_mini_paint
